// File: hw/mshrPkg.sv
// MSHR types seen by the replay queue.
// Phase codes are ordered, so a plain less-than test finds an MSHR still waiting for data.
// The MSHR index is fixed at 2 bits, so at most four MSHRs can be addressed.

package mshrPkg;

    typedef logic [1:0] mshrIdT;

    // Low-order cache index bits of the miss address
    typedef logic [3:0] addrSubsetT;

    // Order matters: every phase before mshrPhaseWriteCache is still waiting for data
    typedef enum logic [2:0] {
        mshrPhaseIdle        = 3'd0,
        mshrPhaseMissRequest = 3'd1,
        mshrPhaseMissWait    = 3'd2,
        mshrPhaseWriteCache  = 3'd3,
        mshrPhaseReadCache   = 3'd4,
        mshrPhaseDone        = 3'd5
    } mshrPhaseT;

endpackage

// File: hw/replayOpPkg.sv
// Op formats held by the replay queue.
// One 16-bit payload word is read either as an integer op or as a memory op.
// activeListPtr takes the top 6 bits in both views, so it can be read without checking the kind.

package replayOpPkg;

    import mshrPkg::*;

    typedef logic [5:0] activeListPtrT;

    typedef enum logic {
        opKindInt = 1'b0,
        opKindMem = 1'b1
    } opKindT;

    typedef struct packed {
        activeListPtrT activeListPtr;
        logic [3:0]    opcode;
        logic [5:0]    destReg;
    } intOpT;

    typedef struct packed {
        activeListPtrT activeListPtr;
        logic          isLoad;
        logic          hasAllocatedMshr;
        mshrIdT        mshrId;
        // Set when the load hit an MSHR that was already allocated
        logic          addrHit;
        addrSubsetT    addrSubset;
        logic          spare;
    } memOpT;

    typedef union packed {
        intOpT intOp;
        memOpT memOp;
    } opPayloadU;

    typedef struct packed {
        opKindT    kind;
        opPayloadU payload;
    } replayOpT;

endpackage

// File: hw/replayControl.sv
// Push/pop control and output register of the replay queue.
// Stored intervals count idle cycles between pushes, so back-to-back records store 0.
// Intervals saturate at maxInterval. Longer gaps replay with maxInterval+1 cycles between them.

`timescale 1ns/1ps

module replayControl import replayOpPkg::*; #(
    parameter int entryNum      = 20,
    parameter int maxInterval   = 7,
    parameter int memLatency    = 3,
    localparam int intervalWidth = $clog2(maxInterval + 1),
    localparam int countWidth    = $clog2(entryNum + 1)
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     recordValid,
    input  logic [intervalWidth-1:0] headInterval,
    input  logic                     empty,
    input  logic                     full,
    input  logic [countWidth-1:0]    count,
    input  logic                     loadHold,
    input  replayOpT                 headOp,
    output logic                     push,
    output logic                     pop,
    output logic [intervalWidth-1:0] recordInterval,
    output logic                     regValid,
    output replayOpT                 regOp,
    output logic                     stallUpper
);

    // Cycles since the last push and since the last pop
    logic [intervalWidth-1:0] inInterval;
    logic [intervalWidth-1:0] outInterval;
    logic                     almostFull;

    assign push = recordValid && !full;

    // The head waits for its spacing and for a pending MSHR
    assign pop = !empty && (outInterval >= headInterval) && !loadHold;

    assign recordInterval = inInterval;

    always_ff @(posedge clk) begin
        if (reset) begin
            inInterval <= '0;
        end else if (push) begin
            inInterval <= '0;
        end else if (inInterval < intervalWidth'(maxInterval)) begin
            inInterval <= inInterval + 1'b1;
        end
    end

    // Keeps counting while the head is held, up to the saturation point
    always_ff @(posedge clk) begin
        if (reset) begin
            outInterval <= '0;
        end else if (pop) begin
            outInterval <= '0;
        end else if (outInterval < intervalWidth'(maxInterval)) begin
            outInterval <= outInterval + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regValid <= 1'b0;
        end else begin
            regValid <= pop;
        end
    end

    // Payload only matters when regValid is set
    always_ff @(posedge clk) begin
        regOp <= headOp;
    end

    // Leave room for the ops already in flight when the stall takes effect
    assign almostFull = count >= countWidth'(entryNum - memLatency);

    assign stallUpper = regValid || almostFull;

endmodule

// File: hw/replayEntryStore.sv
// Circular entry store of the replay queue.
// The head is read combinationally. Writes take effect at the clock edge.
// Push while full or pop while empty is not guarded here.

`timescale 1ns/1ps

module replayEntryStore import replayOpPkg::*; #(
    parameter int entryNum      = 20,
    parameter int maxInterval   = 7,
    localparam int intervalWidth = $clog2(maxInterval + 1),
    localparam int countWidth    = $clog2(entryNum + 1)
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     push,
    input  logic                     pop,
    input  replayOpT                 writeOp,
    input  logic [intervalWidth-1:0] writeInterval,
    output replayOpT                 headOp,
    output logic [intervalWidth-1:0] headInterval,
    output logic                     empty,
    output logic                     full,
    output logic [countWidth-1:0]    count
);

    localparam int indexWidth = $clog2(entryNum);

    logic [indexWidth-1:0]    headPtr;
    logic [indexWidth-1:0]    tailPtr;
    replayOpT                 opMem       [entryNum];
    logic [intervalWidth-1:0] intervalMem [entryNum];

    always_ff @(posedge clk) begin
        if (push) begin
            opMem[tailPtr]       <= writeOp;
            intervalMem[tailPtr] <= writeInterval;
        end
    end

    assign headOp       = opMem[headPtr];
    assign headInterval = intervalMem[headPtr];

    // Pointers wrap at entryNum, which need not be a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else begin
            if (push) begin
                tailPtr <= (tailPtr == indexWidth'(entryNum - 1)) ? '0 : tailPtr + 1'b1;
            end
            if (pop) begin
                headPtr <= (headPtr == indexWidth'(entryNum - 1)) ? '0 : headPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign empty = (count == '0);
    assign full  = (count == countWidth'(entryNum));

endmodule

// File: hw/mshrWaitCheck.sv
// Decides whether the load at the queue head must wait for its MSHR.
// Only the head entry is checked. An integer op never waits.

`timescale 1ns/1ps

module mshrWaitCheck import replayOpPkg::*, mshrPkg::*; #(
    parameter int mshrNum = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  replayOpT                 headOp,
    input  logic       [mshrNum-1:0] mshrValid,
    input  mshrPhaseT  [mshrNum-1:0] mshrPhase,
    input  addrSubsetT [mshrNum-1:0] mshrAddrSubset,
    output logic                     loadHold
);

    memOpT  headMem;
    mshrIdT headMshr;
    logic   headIsLoad;
    logic   dataPending;
    logic   ownerHold;
    logic   hitHold;
    logic   holdEnable;

    // Cleared by reset. The queue is still empty on the first cycle after release
    always_ff @(posedge clk) begin
        if (reset) begin
            holdEnable <= 1'b0;
        end else begin
            holdEnable <= 1'b1;
        end
    end

    always_comb begin
        headMem     = headOp.payload.memOp;
        headMshr    = headMem.mshrId;
        headIsLoad  = (headOp.kind == opKindMem) && headMem.isLoad;
        dataPending = mshrPhase[headMshr] < mshrPhaseWriteCache;

        // The load allocated this MSHR itself
        ownerHold = headMem.hasAllocatedMshr && dataPending;

        // The load hit an MSHR that still serves the same address
        hitHold = headMem.addrHit && mshrValid[headMshr]
                  && (mshrAddrSubset[headMshr] == headMem.addrSubset) && dataPending;
    end

    assign loadHold = holdEnable && headIsLoad && (ownerHold || hitHold);

endmodule

// File: hw/flushFilter.sv
// Removes flushed ops from the replay output after a recovery.
// Only entries in the queue at recovery are suspect. Later records are never filtered.
// The flush range is [flushHeadPtr, flushTailPtr) on the 64-entry active list.

`timescale 1ns/1ps

module flushFilter import replayOpPkg::*; #(
    parameter int entryNum   = 20,
    parameter int mshrNum    = 4,
    localparam int countWidth = $clog2(entryNum + 1)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  recovery,
    input  activeListPtrT         flushHeadPtr,
    input  activeListPtrT         flushTailPtr,
    input  logic [countWidth-1:0] count,
    input  logic                  regValid,
    input  replayOpT              regOp,
    output logic                  replayValid,
    output replayOpT              replayOp,
    output logic                  flushedOpExist,
    output logic [mshrNum-1:0]    mshrRelease
);

    logic [countWidth-1:0] suspectCount;
    activeListPtrT         rangeHead;
    activeListPtrT         rangeTail;
    activeListPtrT         opOffset;
    activeListPtrT         rangeLength;
    memOpT                 regMem;
    logic                  flushHit;

    always_ff @(posedge clk) begin
        if (reset) begin
            suspectCount <= '0;
        end else if (recovery) begin
            suspectCount <= count;
        end else if (suspectCount != '0 && regValid) begin
            suspectCount <= suspectCount - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (recovery) begin
            rangeHead <= flushHeadPtr;
            rangeTail <= flushTailPtr;
        end
    end

    always_comb begin
        regMem = regOp.payload.memOp;

        // Distances from the range head wrap modulo 64
        opOffset    = regOp.payload.intOp.activeListPtr - rangeHead;
        rangeLength = rangeTail - rangeHead;
        flushHit    = (suspectCount != '0) && (opOffset < rangeLength);

        mshrRelease = '0;
        if (regValid && flushHit && regOp.kind == opKindMem
            && regMem.isLoad && regMem.hasAllocatedMshr) begin
            mshrRelease[regMem.mshrId] = 1'b1;
        end
    end

    assign replayValid    = regValid && !flushHit;
    assign replayOp       = regOp;
    assign flushedOpExist = (suspectCount != '0);

endmodule

// File: hw/replayQueueTop.sv
// Replay queue for the scheduler. Ops leave in record order and keep their recorded spacing.
// Producers must obey stallUpper. A record made while the queue is full is dropped.
// The replay appears one cycle after the pop. Flushed ops show replayValid low.

`timescale 1ns/1ps

module replayQueueTop import replayOpPkg::*, mshrPkg::*; #(
    parameter int entryNum    = 20,
    parameter int maxInterval = 7,
    parameter int memLatency  = 3,
    parameter int mshrNum     = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     recordValid,
    input  replayOpT                 recordOp,
    input  logic       [mshrNum-1:0] mshrValid,
    input  mshrPhaseT  [mshrNum-1:0] mshrPhase,
    input  addrSubsetT [mshrNum-1:0] mshrAddrSubset,
    input  logic                     recovery,
    input  activeListPtrT            flushHeadPtr,
    input  activeListPtrT            flushTailPtr,
    output logic                     replayValid,
    output replayOpT                 replayOp,
    output logic                     stallUpper,
    output logic                     flushedOpExist,
    output logic       [mshrNum-1:0] mshrRelease
);

    localparam int intervalWidth = $clog2(maxInterval + 1);
    localparam int countWidth    = $clog2(entryNum + 1);

    logic                     push;
    logic                     pop;
    logic                     empty;
    logic                     full;
    logic                     loadHold;
    logic                     regValid;
    logic [countWidth-1:0]    count;
    logic [intervalWidth-1:0] recordInterval;
    logic [intervalWidth-1:0] headInterval;
    replayOpT                 headOp;
    replayOpT                 regOp;

    replayControl #(
        .entryNum    (entryNum),
        .maxInterval (maxInterval),
        .memLatency  (memLatency)
    ) u_control (
        .clk            (clk),
        .reset          (reset),
        .recordValid    (recordValid),
        .headInterval   (headInterval),
        .empty          (empty),
        .full           (full),
        .count          (count),
        .loadHold       (loadHold),
        .headOp         (headOp),
        .push           (push),
        .pop            (pop),
        .recordInterval (recordInterval),
        .regValid       (regValid),
        .regOp          (regOp),
        .stallUpper     (stallUpper)
    );

    replayEntryStore #(
        .entryNum    (entryNum),
        .maxInterval (maxInterval)
    ) u_store (
        .clk           (clk),
        .reset         (reset),
        .push          (push),
        .pop           (pop),
        .writeOp       (recordOp),
        .writeInterval (recordInterval),
        .headOp        (headOp),
        .headInterval  (headInterval),
        .empty         (empty),
        .full          (full),
        .count         (count)
    );

    mshrWaitCheck #(
        .mshrNum (mshrNum)
    ) u_waitCheck (
        .clk            (clk),
        .reset          (reset),
        .headOp         (headOp),
        .mshrValid      (mshrValid),
        .mshrPhase      (mshrPhase),
        .mshrAddrSubset (mshrAddrSubset),
        .loadHold       (loadHold)
    );

    flushFilter #(
        .entryNum (entryNum),
        .mshrNum  (mshrNum)
    ) u_flushFilter (
        .clk            (clk),
        .reset          (reset),
        .recovery       (recovery),
        .flushHeadPtr   (flushHeadPtr),
        .flushTailPtr   (flushTailPtr),
        .count          (count),
        .regValid       (regValid),
        .regOp          (regOp),
        .replayValid    (replayValid),
        .replayOp       (replayOp),
        .flushedOpExist (flushedOpExist),
        .mshrRelease    (mshrRelease)
    );

endmodule

// File: testbench/replayQueue_properties.sv
// Checks on the push/pop control, bound into every replayControl instance.

`timescale 1ns/1ps

module replayControlProperties (
    input logic clk,
    input logic reset,
    input logic push,
    input logic pop,
    input logic full,
    input logic empty,
    input logic regValid,
    input logic stallUpper
);

    // A replay in the output register always stalls the upper stages
    stallOnReplay: assert property (@(posedge clk) disable iff (reset) regValid |-> stallUpper)
        else $error("stallUpper low while a replay is in the output register");

    noPushWhenFull: assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("push while the queue is full");

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("pop while the queue is empty");

endmodule

bind replayControl replayControlProperties u_properties (.*);

// File: testbench/replayQueueTb.sv
// Testbench for the replay queue at its default parameters.
// Producers obey stallUpper, so no record is dropped here.
// Flush checks assume the queue head is held while the recovery pulse arrives.

`timescale 1ns/1ps

module replayQueueTb import replayOpPkg::*, mshrPkg::*; ();

    localparam int entryNum    = 20;
    localparam int maxInterval = 7;
    localparam int memLatency  = 3;
    localparam int mshrNum     = 4;
    localparam int randomOps   = 30;
    localparam int maxGap      = 9;
    localparam int spacingGaps [10] = '{0, 0, 1, 3, 6, 7, 8, 12, 2, 0};
    // Worst case for one op: its record gap, a stall cycle and its replay spacing
    localparam int opCycles    = maxGap + maxInterval + 4;
    localparam int cycleLimit  = (randomOps + 10 + 5 + 20 + 8) * opCycles + 200;

    logic                     clk;
    logic                     reset;
    logic                     recordValid;
    replayOpT                 recordOp;
    logic       [mshrNum-1:0] mshrValid;
    mshrPhaseT  [mshrNum-1:0] mshrPhase;
    addrSubsetT [mshrNum-1:0] mshrAddrSubset;
    logic                     recovery;
    activeListPtrT            flushHeadPtr;
    activeListPtrT            flushTailPtr;
    logic                     replayValid;
    replayOpT                 replayOp;
    logic                     stallUpper;
    logic                     flushedOpExist;
    logic       [mshrNum-1:0] mshrRelease;

    // Expected ops in record order, with their record gap and flush marks
    replayOpT expOp [$];
    int       expGap [$];
    logic     expSuspect [$];
    logic     expFlush [$];

    integer             seed;
    int                 cycle = 0;
    int                 lastPushCycle = 0;
    int                 lastReplayCycle = 0;
    logic               prevVisible = 1'b0;
    int                 errorCount = 0;
    int                 testCount = 0;
    int                 failedTests = 0;
    int                 testErrorStart = 0;
    logic               stallWatch = 1'b0;
    logic               stallSeen = 1'b0;
    logic [mshrNum-1:0] releaseSeen = '0;

    replayQueueTop #(
        .entryNum    (entryNum),
        .maxInterval (maxInterval),
        .memLatency  (memLatency),
        .mshrNum     (mshrNum)
    ) u_dut (
        .clk            (clk),
        .reset          (reset),
        .recordValid    (recordValid),
        .recordOp       (recordOp),
        .mshrValid      (mshrValid),
        .mshrPhase      (mshrPhase),
        .mshrAddrSubset (mshrAddrSubset),
        .recovery       (recovery),
        .flushHeadPtr   (flushHeadPtr),
        .flushTailPtr   (flushTailPtr),
        .replayValid    (replayValid),
        .replayOp       (replayOp),
        .stallUpper     (stallUpper),
        .flushedOpExist (flushedOpExist),
        .mshrRelease    (mshrRelease)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Flushed when the pointer lies in [head, tail) on the circular active list
    function automatic logic inFlushRange(activeListPtrT ptr, activeListPtrT head,
                                          activeListPtrT tail);
        if (head <= tail) begin
            return (ptr >= head) && (ptr < tail);
        end
        return (ptr >= head) || (ptr < tail);
    endfunction

    // Replays keep the record gap, up to maxInterval cycles
    function automatic int minReplayGap(int recordGap);
        return (recordGap < maxInterval) ? recordGap : maxInterval;
    endfunction

    function automatic replayOpT makeIntOp(activeListPtrT ptr);
        replayOpT op;
        op = '0;
        op.kind = opKindInt;
        op.payload.intOp.activeListPtr = ptr;
        op.payload.intOp.opcode = ptr[3:0];
        op.payload.intOp.destReg = ~ptr;
        return op;
    endfunction

    function automatic replayOpT makeMemOp(activeListPtrT ptr, logic isLoad, logic alloc,
                                           mshrIdT id);
        replayOpT op;
        op = '0;
        op.kind = opKindMem;
        op.payload.memOp.activeListPtr = ptr;
        op.payload.memOp.isLoad = isLoad;
        op.payload.memOp.hasAllocatedMshr = alloc;
        op.payload.memOp.mshrId = id;
        op.payload.memOp.addrSubset = ptr[3:0];
        return op;
    endfunction

    task automatic idle(int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Waits out stallUpper, then records one op at the next edge
    task automatic recordOne(replayOpT op);
        while (stallUpper) begin
            idle(1);
        end
        recordValid = 1'b1;
        recordOp = op;
        @(posedge clk);
        #1;
        recordValid = 1'b0;
        expOp.push_back(op);
        expGap.push_back(cycle - lastPushCycle);
        expSuspect.push_back(1'b0);
        expFlush.push_back(1'b0);
        lastPushCycle = cycle;
    endtask

    task automatic waitDrain();
        while (expOp.size() != 0) begin
            idle(1);
        end
        idle(2);
    endtask

    task automatic dropFront();
        void'(expOp.pop_front());
        void'(expGap.pop_front());
        void'(expSuspect.pop_front());
        void'(expFlush.pop_front());
    endtask

    task automatic finishTest(string name);
        testCount++;
        if (errorCount != testErrorStart) begin
            failedTests++;
        end
        $display("Test %0d %s: %s", testCount, name,
                 (errorCount == testErrorStart) ? "ok" : "errors found");
        testErrorStart = errorCount;
    endtask

    task automatic checkReplay();
        replayOpT expected;
        // Flushed ops ahead of this one never show replayValid
        while (expOp.size() != 0 && expFlush[0]) begin
            dropFront();
            prevVisible = 1'b0;
        end
        if (expOp.size() == 0) begin
            $display("A replay came out with no op left to expect");
            errorCount++;
        end else begin
            expected = expOp[0];
            assert (replayOp.kind == expected.kind) else begin
                $display("ERROR: replayOp.kind expected %h got %h",
                         expected.kind, replayOp.kind);
                errorCount++;
            end
            if (expected.kind == opKindMem) begin
                assert (replayOp.payload.memOp == expected.payload.memOp) else begin
                    $display("ERROR: replayOp.payload.memOp expected %h got %h",
                             expected.payload.memOp, replayOp.payload.memOp);
                    errorCount++;
                end
            end else begin
                assert (replayOp.payload.intOp == expected.payload.intOp) else begin
                    $display("ERROR: replayOp.payload.intOp expected %h got %h",
                             expected.payload.intOp, replayOp.payload.intOp);
                    errorCount++;
                end
            end
            assert (flushedOpExist == expSuspect[0]) else begin
                $display("ERROR: flushedOpExist expected %h got %h",
                         expSuspect[0], flushedOpExist);
                errorCount++;
            end
            if (prevVisible) begin
                assert (cycle - lastReplayCycle >= minReplayGap(expGap[0])) else begin
                    $display("Replay came %0d cycles after the previous one, at least %0d needed",
                             cycle - lastReplayCycle, minReplayGap(expGap[0]));
                    errorCount++;
                end
            end
            prevVisible = 1'b1;
            lastReplayCycle = cycle;
            dropFront();
        end
    endtask

    // Outputs are sampled on the falling edge, away from the drive time
    always @(negedge clk) begin
        if (!reset) begin
            releaseSeen = releaseSeen | mshrRelease;
            if (stallWatch) begin
                // A replay in flight also stalls, so only cycles without one count
                if (stallUpper && !replayValid) begin
                    stallSeen = 1'b1;
                end
                assert (expOp.size() < entryNum - memLatency || stallUpper) else begin
                    $display("ERROR: stallUpper expected 1 got %h with %0d ops outstanding",
                             stallUpper, expOp.size());
                    errorCount++;
                end
            end
            if (replayValid) begin
                checkReplay();
            end
        end
    end

    initial begin
        replayOpT           op;
        activeListPtrT      ptr;
        logic [mshrNum-1:0] expRelease;
        seed = 32'hd916;
        ptr = '0;
        reset = 1'b1;
        recordValid = 1'b0;
        recordOp = '0;
        mshrValid = '1;
        mshrAddrSubset = '0;
        recovery = 1'b0;
        flushHeadPtr = '0;
        flushTailPtr = '0;
        for (int i = 0; i < mshrNum; i++) begin
            mshrPhase[i] = mshrPhaseDone;
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (!replayValid && !stallUpper && !flushedOpExist && mshrRelease == '0) else begin
            $display("ERROR: after reset replayValid %h stallUpper %h flushedOpExist %h",
                     replayValid, stallUpper, flushedOpExist);
            errorCount++;
        end

        // All MSHRs hold their data, so no random load waits
        for (int n = 0; n < randomOps; n++) begin
            op = replayOpT'(17'($random(seed)));
            recordOne(op);
            idle($unsigned($random(seed)) % (maxGap + 1));
        end
        waitDrain();
        finishTest("order and payload");

        // A held head builds a backlog, so the stored spacing alone sets the replay gaps
        mshrPhase[3] = mshrPhaseMissWait;
        recordOne(makeMemOp(6'd20, 1'b1, 1'b1, 2'd3));
        foreach (spacingGaps[i]) begin
            recordOne(makeIntOp(6'(i)));
            idle(spacingGaps[i]);
        end
        mshrPhase[3] = mshrPhaseWriteCache;
        waitDrain();
        finishTest("spacing");

        mshrPhase[0] = mshrPhaseMissWait;
        recordOne(makeMemOp(6'd40, 1'b1, 1'b1, 2'd0));
        for (int i = 0; i < 4; i++) begin
            recordOne(makeIntOp(6'(41 + i)));
        end
        idle(20);
        assert (expOp.size() == 5) else begin
            $display("An op replayed while the head load was waiting for its MSHR");
            errorCount++;
        end
        mshrPhase[0] = mshrPhaseWriteCache;
        waitDrain();
        finishTest("load hold");

        // A held load at the head lets the queue fill up
        stallSeen = 1'b0;
        stallWatch = 1'b1;
        mshrPhase[1] = mshrPhaseMissRequest;
        recordOne(makeMemOp(6'd50, 1'b1, 1'b1, 2'd1));
        repeat (30) begin
            if (stallUpper) begin
                idle(1);
            end else begin
                recordOne(makeIntOp(ptr));
                ptr = ptr + 1'b1;
            end
        end
        mshrPhase[1] = mshrPhaseWriteCache;
        waitDrain();
        stallWatch = 1'b0;
        assert (stallSeen) else begin
            $display("stallUpper never rose while the queue was filling");
            errorCount++;
        end
        finishTest("almost-full stall");

        mshrPhase[0] = mshrPhaseMissWait;
        recordOne(makeMemOp(6'd62, 1'b1, 1'b1, 2'd0));
        recordOne(makeIntOp(6'd7));
        recordOne(makeMemOp(6'd2, 1'b1, 1'b1, 2'd2));
        recordOne(makeIntOp(6'd61));
        recordOne(makeIntOp(6'd30));
        recordOne(makeMemOp(6'd3, 1'b0, 1'b0, 2'd3));
        recordOne(makeIntOp(6'd5));
        // This range wraps past the end of the active list
        flushHeadPtr = 6'd60;
        flushTailPtr = 6'd5;
        recovery = 1'b1;
        @(posedge clk);
        #1;
        recovery = 1'b0;
        expRelease = '0;
        foreach (expOp[i]) begin
            expSuspect[i] = 1'b1;
            expFlush[i] = inFlushRange(expOp[i].payload.intOp.activeListPtr,
                                       flushHeadPtr, flushTailPtr);
            if (expFlush[i] && expOp[i].kind == opKindMem && expOp[i].payload.memOp.isLoad
                && expOp[i].payload.memOp.hasAllocatedMshr) begin
                expRelease[expOp[i].payload.memOp.mshrId] = 1'b1;
            end
        end
        assert (flushedOpExist) else begin
            $display("flushedOpExist stayed low after the recovery pulse");
            errorCount++;
        end
        // Recorded after recovery, so it replays although it is in the range
        recordOne(makeIntOp(6'd1));
        mshrPhase[0] = mshrPhaseWriteCache;
        waitDrain();
        assert (!flushedOpExist) else begin
            $display("flushedOpExist stayed high after every suspect op had passed");
            errorCount++;
        end
        assert (releaseSeen == expRelease) else begin
            $display("ERROR: mshrRelease expected %h got %h", expRelease, releaseSeen);
            errorCount++;
        end
        finishTest("selective flush");

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim.f
hw/mshrPkg.sv
hw/replayOpPkg.sv
hw/replayControl.sv
hw/replayEntryStore.sv
hw/mshrWaitCheck.sv
hw/flushFilter.sv
hw/replayQueueTop.sv
testbench/replayQueue_properties.sv
testbench/replayQueueTb.sv

// File: Bender.yml
package:
  name: replay_queue

sources:
  - hw/mshrPkg.sv
  - hw/replayOpPkg.sv
  - hw/replayControl.sv
  - hw/replayEntryStore.sv
  - hw/mshrWaitCheck.sv
  - hw/flushFilter.sv
  - hw/replayQueueTop.sv
  - target: simulation
    files:
      - testbench/replayQueue_properties.sv
      - testbench/replayQueueTb.sv
